/* compile.f */
common/sys86_map_pkg.sv
common/sys86_bus_pkg.sv
decode/main_decoder.sv
decode/sub_decoder.sv
rtl/master_bus_mux.sv
rtl/cpu_subsystem.sv
test/cpu_subsystem_chk.sv
test/tb_cpu_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only on the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_subsystem \
	-f compile.f -o tb_cpu_subsystem \
	&& ./obj_dir/tb_cpu_subsystem | tee /dev/stderr | grep -q "^Simulation passed$" \
	&& { echo "run.sh: PASS"; exit 0; } \
	|| { echo "run.sh: FAIL"; exit 1; }

/* test/tb_cpu_subsystem.sv */
`timescale 1ns/10ps

module tb_cpu_subsystem
	import sys86_map_pkg::*;
	import sys86_bus_pkg::*;
();

	// One stimulus row, cpu is high for the sub CPU
	typedef struct packed {
		logic cpu;
		logic [15:0] addr;
		logic we;
		logic bus;
		region_t region;
		logic bank;
		logic hold;
	} vec_t;

	logic clk_6m;
	logic reset;
	logic vblank;
	logic main_req_valid;
	cpu_req_t main_req;
	logic sub_req_valid;
	cpu_req_t sub_req;
	logic mbus_valid;
	mbus_t mbus;
	logic main_irq;
	logic sub_irq;
	logic bank;
	logic sub_hold;

	vec_t vec_q[$];
	string name_q[$];
	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	cpu_subsystem i_dut (.*);

	always #4 clk_6m = ~clk_6m;

	task automatic add_vec(input string name, input logic cpu, input logic [15:0] addr,
			input logic we, input logic bus, input region_t region,
			input logic bank_exp, input logic hold_exp);
		vec_t v;
		v.cpu = cpu;
		v.addr = addr;
		v.we = we;
		v.bus = bus;
		v.region = region;
		v.bank = bank_exp;
		v.hold = hold_exp;
		vec_q.push_back(v);
		name_q.push_back(name);
	endtask

	task automatic report_mismatch(input string name, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %s %s expected %h actual %h", name, field, exp, act);
		err_count++;
	endtask

	task automatic report_problem(input string name, input string what);
		$display("[ERROR] %s %s", name, what);
		err_count++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("%-20s ok", name);
			pass_count++;
		end else begin
			$display("%-20s FAILED", name);
			fail_count++;
		end
	endtask

	// One strobe cycle from the chosen CPU
	task automatic issue(input logic cpu, input cpu_req_t r);
		@(posedge clk_6m);
		if (cpu) begin
			sub_req_valid <= 1'b1;
			sub_req <= r;
		end else begin
			main_req_valid <= 1'b1;
			main_req <= r;
		end
		@(posedge clk_6m);
		main_req_valid <= 1'b0;
		sub_req_valid <= 1'b0;
	endtask

	task automatic run_vec(input int idx);
		vec_t v;
		cpu_req_t r;
		mbus_t exp;
		mbus_t got;
		logic [31:0] rnd;
		int waited;
		int errs_before;
		v = vec_q[idx];
		rnd = $urandom;
		r.addr = v.addr;
		r.we = v.we;
		r.data = rnd[7:0];
		// Main control writes carry the new bank and hold bits
		// Other accesses carry the inverse so a stray load shows
		if (!v.cpu && v.we && v.region == control)
			r.data[1:0] = {v.hold, v.bank};
		else
			r.data[1:0] = ~{v.hold, v.bank};
		exp.owner = v.cpu;
		exp.region = v.region;
		exp.we = v.we;
		exp.addr = v.addr[12:0];
		exp.data = r.data;
		errs_before = err_count;
		issue(v.cpu, r);
		@(negedge clk_6m);
		waited = 1;
		while (!mbus_valid && waited < 8) begin
			@(negedge clk_6m);
			waited++;
		end
		got = mbus;
		if (v.bus && !mbus_valid)
			report_problem(name_q[idx], "no master bus cycle within 8 cycles");
		if (v.bus && mbus_valid && got != exp)
			report_mismatch(name_q[idx], "mbus", {6'b0, exp}, {6'b0, got});
		if (!v.bus && mbus_valid)
			report_problem(name_q[idx], "local access appeared on the master bus");
		if (bank != v.bank)
			report_mismatch(name_q[idx], "bank", {31'b0, v.bank}, {31'b0, bank});
		if (sub_hold != v.hold)
			report_mismatch(name_q[idx], "sub_hold", {31'b0, v.hold}, {31'b0, sub_hold});
		finish_test(name_q[idx], errs_before);
		// Keep the request rate below one per four cycles
		repeat (2) @(posedge clk_6m);
	endtask

	task automatic run_dual();
		cpu_req_t mr;
		cpu_req_t sr;
		mbus_t exp_main;
		mbus_t exp_sub;
		mbus_t got;
		logic [31:0] rnd;
		logic seen_main;
		logic seen_sub;
		int waited;
		int errs_before;
		errs_before = err_count;
		rnd = $urandom;
		mr.addr = 16'h4abc;
		mr.we = 1'b1;
		mr.data = rnd[7:0];
		sr.addr = 16'ha123;
		sr.we = 1'b1;
		sr.data = rnd[15:8];
		exp_main = {1'b0, object, mr.we, mr.addr[12:0], mr.data};
		exp_sub = {1'b1, latch1, sr.we, sr.addr[12:0], sr.data};
		@(posedge clk_6m);
		main_req_valid <= 1'b1;
		main_req <= mr;
		sub_req_valid <= 1'b1;
		sub_req <= sr;
		@(posedge clk_6m);
		main_req_valid <= 1'b0;
		sub_req_valid <= 1'b0;
		seen_main = 1'b0;
		seen_sub = 1'b0;
		waited = 0;
		while (!(seen_main && seen_sub) && waited < 8) begin
			@(negedge clk_6m);
			waited++;
			got = mbus;
			if (mbus_valid && got.owner) begin
				seen_sub = 1'b1;
				if (got != exp_sub)
					report_mismatch("dual_request", "sub mbus", {6'b0, exp_sub}, {6'b0, got});
			end
			if (mbus_valid && !got.owner) begin
				seen_main = 1'b1;
				if (got != exp_main)
					report_mismatch("dual_request", "main mbus", {6'b0, exp_main}, {6'b0, got});
			end
		end
		if (!(seen_main && seen_sub))
			report_problem("dual_request", "both requests did not reach the master bus");
		finish_test("dual_request", errs_before);
		repeat (2) @(posedge clk_6m);
	endtask

	task automatic run_vblank();
		cpu_req_t r;
		int waited;
		int errs_before;
		errs_before = err_count;
		@(posedge clk_6m);
		vblank <= 1'b1;
		@(posedge clk_6m);
		vblank <= 1'b0;
		@(negedge clk_6m);
		waited = 1;
		while (!(main_irq && sub_irq) && waited < 8) begin
			@(negedge clk_6m);
			waited++;
		end
		if (!(main_irq && sub_irq))
			report_problem("vblank_irq", "interrupts did not rise after vblank");
		// Acknowledge keeps bank and hold set
		r.addr = 16'h6000;
		r.we = 1'b1;
		r.data = 8'h03;
		issue(1'b0, r);
		@(negedge clk_6m);
		waited = 1;
		while (main_irq && waited < 8) begin
			@(negedge clk_6m);
			waited++;
		end
		if (main_irq)
			report_problem("vblank_irq", "main interrupt stayed high after its acknowledge");
		if (!sub_irq)
			report_problem("vblank_irq", "sub interrupt dropped on the main acknowledge");
		issue(1'b1, r);
		@(negedge clk_6m);
		waited = 1;
		while (sub_irq && waited < 8) begin
			@(negedge clk_6m);
			waited++;
		end
		if (sub_irq)
			report_problem("vblank_irq", "sub interrupt stayed high after its acknowledge");
		finish_test("vblank_irq", errs_before);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		clk_6m = 1'b0;
		reset = 1'b1;
		vblank = 1'b0;
		main_req_valid = 1'b0;
		main_req = '0;
		sub_req_valid = 1'b0;
		sub_req = '0;
		void'($urandom(32'h4df5));

		// name, cpu, addr, we, bus, region, bank, hold
		add_vec("main_scroll0_wr", 1'b0, 16'h0155, 1'b1, 1'b1, scroll0, 1'b0, 1'b0);
		add_vec("main_scroll0_rd", 1'b0, 16'h1e02, 1'b0, 1'b1, scroll0, 1'b0, 1'b0);
		add_vec("main_scroll1_wr", 1'b0, 16'h2345, 1'b1, 1'b1, scroll1, 1'b0, 1'b0);
		add_vec("main_scroll1_rd", 1'b0, 16'h3fff, 1'b0, 1'b1, scroll1, 1'b0, 1'b0);
		add_vec("main_object_wr", 1'b0, 16'h4800, 1'b1, 1'b1, object, 1'b0, 1'b0);
		add_vec("main_object_rd", 1'b0, 16'h5a5a, 1'b0, 1'b1, object, 1'b0, 1'b0);
		add_vec("main_latch0_wr", 1'b0, 16'h8001, 1'b1, 1'b1, latch0, 1'b0, 1'b0);
		add_vec("main_latch0_rd", 1'b0, 16'h9c3c, 1'b0, 1'b1, latch0, 1'b0, 1'b0);
		add_vec("main_latch1_wr", 1'b0, 16'ha7e1, 1'b1, 1'b1, latch1, 1'b0, 1'b0);
		add_vec("main_latch1_rd", 1'b0, 16'hbfff, 1'b0, 1'b1, latch1, 1'b0, 1'b0);
		add_vec("main_backcol_wr", 1'b0, 16'hc010, 1'b1, 1'b1, backcolor, 1'b0, 1'b0);
		add_vec("main_backcol_rd", 1'b0, 16'hdead, 1'b0, 1'b1, backcolor, 1'b0, 1'b0);
		add_vec("main_ctrl_bank", 1'b0, 16'h6000, 1'b1, 1'b0, control, 1'b1, 1'b0);
		add_vec("main_ctrl_rd", 1'b0, 16'h7123, 1'b0, 1'b0, control, 1'b1, 1'b0);
		add_vec("main_rom_rd", 1'b0, 16'he000, 1'b0, 1'b0, rom, 1'b1, 1'b0);
		add_vec("main_rom_wr", 1'b0, 16'hf00f, 1'b1, 1'b0, rom, 1'b1, 1'b0);
		add_vec("main_ctrl_hold", 1'b0, 16'h6001, 1'b1, 1'b0, control, 1'b0, 1'b1);
		add_vec("sub_scroll0_wr", 1'b1, 16'h0042, 1'b1, 1'b1, scroll0, 1'b0, 1'b1);
		add_vec("sub_object_rd", 1'b1, 16'h4321, 1'b0, 1'b1, object, 1'b0, 1'b1);
		add_vec("sub_latch0_rd", 1'b1, 16'h9000, 1'b0, 1'b1, latch0, 1'b0, 1'b1);
		add_vec("sub_latch1_wr", 1'b1, 16'hb00b, 1'b1, 1'b1, latch1, 1'b0, 1'b1);
		add_vec("sub_backcol_rd", 1'b1, 16'hc123, 1'b0, 1'b0, backcolor, 1'b0, 1'b1);
		add_vec("sub_rom_wr", 1'b1, 16'hfff0, 1'b1, 1'b0, rom, 1'b0, 1'b1);
		add_vec("main_ctrl_both", 1'b0, 16'h7000, 1'b1, 1'b0, control, 1'b1, 1'b1);

		repeat (3) @(posedge clk_6m);
		reset <= 1'b0;
		repeat (2) @(posedge clk_6m);

		for (int i = 0; i < vec_q.size(); i++)
			run_vec(i);
		run_dual();
		run_vblank();

		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			pass_count + fail_count, pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* test/cpu_subsystem_chk.sv */
`timescale 1ns/10ps

module cpu_subsystem_chk
	import sys86_map_pkg::*;
	import sys86_bus_pkg::*;
(
	input logic clk_6m,
	input logic reset,
	input logic mbus_valid,
	input mbus_t mbus,
	input logic main_irq,
	input logic sub_irq
);

	// Slots sit two phases apart
	a_no_back_to_back: assert property (
		@(posedge clk_6m) disable iff (reset) mbus_valid |=> !mbus_valid
	) else $error("mbus_valid high in two consecutive cycles");

	// Local regions stay inside the decoders
	a_no_local_region: assert property (
		@(posedge clk_6m) disable iff (reset)
		mbus_valid |-> (mbus.region != control && mbus.region != rom)
	) else $error("local region on the master bus");

	a_irq_reset: assert property (
		@(posedge clk_6m) reset |=> (!main_irq && !sub_irq)
	) else $error("interrupt high after a reset cycle");

endmodule

bind cpu_subsystem cpu_subsystem_chk i_chk (
	.clk_6m(clk_6m),
	.reset(reset),
	.mbus_valid(mbus_valid),
	.mbus(mbus),
	.main_irq(main_irq),
	.sub_irq(sub_irq)
);

/* rtl/cpu_subsystem.sv */
`timescale 1ns/10ps

module cpu_subsystem
	import sys86_bus_pkg::*;
(
	input logic clk_6m,
	input logic reset,
	input logic vblank,
	input logic main_req_valid,
	input cpu_req_t main_req,
	input logic sub_req_valid,
	input cpu_req_t sub_req,
	output logic mbus_valid,
	output mbus_t mbus,
	output logic main_irq,
	output logic sub_irq,
	output logic bank,
	output logic sub_hold
);

	logic main_dec_valid;
	dec_req_t main_dec_req;
	logic sub_dec_valid;
	dec_req_t sub_dec_req;

	// Main CPU side, owns bank and sub hold
	main_decoder u_main_dec (
		.clk_6m(clk_6m),
		.reset(reset),
		.vblank(vblank),
		.req_valid(main_req_valid),
		.req(main_req),
		.dec_valid(main_dec_valid),
		.dec_req(main_dec_req),
		.irq(main_irq),
		.bank(bank),
		.sub_hold(sub_hold)
	);

	sub_decoder u_sub_dec (
		.clk_6m(clk_6m),
		.reset(reset),
		.vblank(vblank),
		.req_valid(sub_req_valid),
		.req(sub_req),
		.dec_valid(sub_dec_valid),
		.dec_req(sub_dec_req),
		.irq(sub_irq)
	);

	// Time shared master bus to the video chips
	master_bus_mux u_mux (
		.clk_6m(clk_6m),
		.reset(reset),
		.main_valid(main_dec_valid),
		.main_dec(main_dec_req),
		.sub_valid(sub_dec_valid),
		.sub_dec(sub_dec_req),
		.mbus_valid(mbus_valid),
		.mbus(mbus)
	);

endmodule

/* rtl/master_bus_mux.sv */
`timescale 1ns/10ps

module master_bus_mux
	import sys86_map_pkg::*;
	import sys86_bus_pkg::*;
(
	input logic clk_6m,
	input logic reset,
	input logic main_valid,
	input dec_req_t main_dec,
	input logic sub_valid,
	input dec_req_t sub_dec,
	output logic mbus_valid,
	output mbus_t mbus
);

	logic [PHASE_W-1:0] phase;
	logic main_pend;
	logic sub_pend;
	dec_req_t main_buf;
	dec_req_t sub_buf;
	dec_req_t src;
	logic main_issue;
	logic sub_issue;

	// Only one slot matches per phase
	assign main_issue = main_pend && (phase == MAIN_SLOT);
	assign sub_issue = sub_pend && (phase == SUB_SLOT);

	////////////////////////////////////////
	// Phase counter and pending flags
	////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			phase <= '0;
			main_pend <= 1'b0;
			sub_pend <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
			// New request wins over the one leaving this cycle
			if (main_valid)
				main_pend <= 1'b1;
			else if (main_issue)
				main_pend <= 1'b0;
			if (sub_valid)
				sub_pend <= 1'b1;
			else if (sub_issue)
				sub_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (main_valid)
			main_buf <= main_dec;
		if (sub_valid)
			sub_buf <= sub_dec;
	end

	////////////////////////////////////////
	// Master bus drive
	////////////////////////////////////////

	assign src = sub_issue ? sub_buf : main_buf;
	assign mbus_valid = main_issue || sub_issue;

	always_comb begin
		mbus.owner = sub_issue ? OWNER_SUB : OWNER_MAIN;
		mbus.region = src.region;
		mbus.we = src.we;
		mbus.addr = src.addr;
		mbus.data = src.data;
	end

endmodule

/* decode/sub_decoder.sv */
`timescale 1ns/10ps

module sub_decoder
	import sys86_map_pkg::*;
	import sys86_bus_pkg::*;
(
	input logic clk_6m,
	input logic reset,
	input logic vblank,
	input logic req_valid,
	input cpu_req_t req,
	output logic dec_valid,
	output dec_req_t dec_req,
	output logic irq
);

	region_t region;
	logic shared;
	logic ctrl_wr;
	logic vblank_q;

	assign region = region_t'(req.addr[REGION_MSB:REGION_LSB]);

	// Upper two regions are local program ROM here
	always_comb begin
		case (region)
			scroll0, scroll1, object, latch0, latch1: shared = 1'b1;
			default: shared = 1'b0;
		endcase
	end

	// Any control write acknowledges the interrupt
	assign ctrl_wr = req_valid && req.we && (region == control);

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			dec_valid <= 1'b0;
			vblank_q <= 1'b0;
			irq <= 1'b0;
		end else begin
			dec_valid <= req_valid && shared;
			vblank_q <= vblank;
			if (vblank && !vblank_q)
				irq <= 1'b1;
			else if (ctrl_wr)
				irq <= 1'b0;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (req_valid && shared) begin
			dec_req.region <= region;
			dec_req.we <= req.we;
			dec_req.addr <= req.addr[MBUS_ADDR_W-1:0];
			dec_req.data <= req.data;
		end
	end

endmodule

/* decode/main_decoder.sv */
`timescale 1ns/10ps

module main_decoder
	import sys86_map_pkg::*;
	import sys86_bus_pkg::*;
(
	input logic clk_6m,
	input logic reset,
	input logic vblank,
	input logic req_valid,
	input cpu_req_t req,
	output logic dec_valid,
	output dec_req_t dec_req,
	output logic irq,
	output logic bank,
	output logic sub_hold
);

	region_t region;
	logic shared;
	logic ctrl_wr;
	logic vblank_q;
	logic vblank_rise;

	assign region = region_t'(req.addr[REGION_MSB:REGION_LSB]);

	// Everything but control and rom goes out to the master bus
	always_comb begin
		case (region)
			control, rom: shared = 1'b0;
			default: shared = 1'b1;
		endcase
	end

	assign ctrl_wr = req_valid && req.we && (region == control);
	assign vblank_rise = vblank && !vblank_q;

	////////////////////////////////////////
	// Control state
	////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			dec_valid <= 1'b0;
			vblank_q <= 1'b0;
			irq <= 1'b0;
			bank <= 1'b0;
			sub_hold <= 1'b0;
		end else begin
			dec_valid <= req_valid && shared;
			vblank_q <= vblank;
			if (ctrl_wr) begin
				bank <= req.data[CTRL_BANK_BIT];
				sub_hold <= req.data[CTRL_HOLD_BIT];
			end
			// A new vblank edge beats an acknowledge
			if (vblank_rise)
				irq <= 1'b1;
			else if (ctrl_wr)
				irq <= 1'b0;
		end
	end

	// Payload, meaningful only with dec_valid
	always_ff @(posedge clk_6m) begin
		if (req_valid && shared) begin
			dec_req.region <= region;
			dec_req.we <= req.we;
			dec_req.addr <= req.addr[MBUS_ADDR_W-1:0];
			dec_req.data <= req.data;
		end
	end

endmodule

/* common/sys86_bus_pkg.sv */
package sys86_bus_pkg;

	import sys86_map_pkg::*;

	// Owner tag on the master bus
	localparam logic OWNER_MAIN = 1'b0;
	localparam logic OWNER_SUB = 1'b1;

	// Raw bus cycle from a CPU
	typedef struct packed {
		logic [CPU_ADDR_W-1:0] addr;
		logic we;
		logic [DATA_W-1:0] data;
	} cpu_req_t;

	// Shared region access after decode
	typedef struct packed {
		region_t region;
		logic we;
		logic [MBUS_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} dec_req_t;

	// Master bus cycle, owner high for the sub CPU
	typedef struct packed {
		logic owner;
		region_t region;
		logic we;
		logic [MBUS_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mbus_t;

endpackage

/* common/sys86_map_pkg.sv */
package sys86_map_pkg;

	////////////////////////////////////////
	// CPU bus widths
	////////////////////////////////////////

	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W = 8;

	// Region field in the CPU address
	localparam int REGION_MSB = 15;
	localparam int REGION_LSB = 13;

	// Master bus carries the low address bits only
	localparam int MBUS_ADDR_W = 13;

	////////////////////////////////////////
	// Memory map regions
	////////////////////////////////////////

	// Sub side reads backcolor as local program ROM
	typedef enum logic [2:0] {
		scroll0 = 3'b000,
		scroll1 = 3'b001,
		object = 3'b010,
		control = 3'b011,
		latch0 = 3'b100,
		latch1 = 3'b101,
		backcolor = 3'b110,
		rom = 3'b111
	} region_t;

	// Control register data bits
	localparam int CTRL_BANK_BIT = 0;
	localparam int CTRL_HOLD_BIT = 1;

	////////////////////////////////////////
	// Master bus slot timing
	////////////////////////////////////////

	// Four phases, the 2H alternation
	localparam int PHASE_W = 2;
	localparam logic [PHASE_W-1:0] MAIN_SLOT = 2'd0;
	localparam logic [PHASE_W-1:0] SUB_SLOT = 2'd2;

endpackage
